// File: hdl/mac_pkg.sv
// shared vector types for byte, crc, length and bus paths
// ethernet framing constants (preamble, sfd, fcs)
// crc-32 constants in reflected form
// frame buffer sizes and Wishbone register word addresses

package mac_pkg;

  //////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////
  typedef logic [7:0]  byte_t;       // one octet on any byte path
  typedef logic [31:0] crc_t;
  typedef logic [10:0] frame_len_t;  // payload length in bytes
  typedef logic [10:0] buf_adr_t;    // frame memory index
  typedef logic [11:0] wb_adr_t;     // word address
  typedef logic [31:0] wb_data_t;

  // framing
  localparam byte_t PREAMBLE_BYTE = 8'h55;
  localparam byte_t SFD_BYTE      = 8'hd5;
  localparam int    PREAMBLE_LEN  = 7;   // 55h bytes before the sfd
  localparam int    FCS_LEN       = 4;

  // ieee 802.3 crc-32, lsb first
  localparam crc_t CRC_INIT      = 32'hffff_ffff;
  localparam crc_t CRC_POLY_REFL = 32'hedb8_8320;

  // buffer limits
  localparam int MAX_FRAME_LEN = 1536;
  localparam int BUF_DEPTH     = 2048;

  // registers have bit 11 set, otherwise bits 10:0 index the frame memory
  localparam wb_adr_t REG_CTRL   = 12'h800;  // bit 0 starts a frame
  localparam wb_adr_t REG_LEN    = 12'h801;  // payload length
  localparam wb_adr_t REG_STATUS = 12'h802;  // busy and sent count

endpackage

// File: hdl/crc_if.sv
// byte path between the transmit controller and the crc engine
// controller and engine modports

`timescale 1ns/1ps

interface crc_if
  import mac_pkg::*;
();

  logic  en;      // fold din this cycle
  logic  init;    // reload CRC_INIT, wins over en
  byte_t din;
  crc_t  result;  // running crc, registered

  modport ctrl (
    output en,
    output init,
    output din,
    input  result
  );

  modport engine (
    input  en,
    input  init,
    input  din,
    output result
  );

endinterface

// File: hdl/crc32_d8.sv
// byte-wide crc-32 engine, reflected form
// one byte folded per enabled cycle, result registered
// synchronous reload on init

`timescale 1ns/1ps

module crc32_d8
  import mac_pkg::*;
(
  input logic   clk,
  input logic   rst_n,
  crc_if.engine crc
);

  crc_t crc_q;
  crc_t crc_nxt;

  //////////////////////////////////////////////////
  // next value, eight bit steps lsb first
  //////////////////////////////////////////////////
  always_comb
  begin
    crc_nxt = crc_q ^ crc_t'(crc.din);  // byte enters at the low end
    for (int i = 0; i < 8; i++)
    begin
      if (crc_nxt[0])
        crc_nxt = (crc_nxt >> 1) ^ CRC_POLY_REFL;
      else
        crc_nxt = crc_nxt >> 1;
    end
  end

  //////////////////////////////////////////////////
  // crc register
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      crc_q <= CRC_INIT;
    else if (crc.init)
      crc_q <= CRC_INIT;      // start of a new frame
    else if (crc.en)
      crc_q <= crc_nxt;
  end

  assign crc.result = crc_q;  // complement is taken by the controller

endmodule

// File: hdl/mac_tx.sv
// transmit controller for the byte-wide MAC output
// fsm with byte counter for preamble, sfd, payload and fcs
// payload fetch from the frame source via data_req
// crc engine control and fcs byte select
// two-stage output pipeline for tx_data and tx_en

`timescale 1ns/1ps

module mac_tx
  import mac_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  tx_ready,
  input  logic  frame_last,
  input  byte_t frame_data,
  output logic  data_req,
  output logic  send_end,
  output logic  tx_en,
  output byte_t tx_data,
  crc_if.ctrl   crc
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_PREAMBLE,
    S_DATA,
    S_FCS,
    S_DONE
  } tx_state_t;

  tx_state_t  state;
  tx_state_t  state_nxt;
  logic [3:0] cnt;           // bytes left in preamble or fcs, current one included
  byte_t      data_dly;      // payload lined up with the data state
  logic       last_dly;
  byte_t      fcs_byte;
  byte_t      tx_data_pre;   // first output stage
  logic       tx_en_pre;
  logic       send_end_pre;

  //////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= S_IDLE;
    else
      state <= state_nxt;
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      S_IDLE:
        if (tx_ready)
          state_nxt = S_PREAMBLE;
      S_PREAMBLE:
        if (cnt == 4'd1)
          state_nxt = S_DATA;  // sfd on this cycle
      S_DATA:
        if (last_dly)
          state_nxt = S_FCS;
      S_FCS:
        if (cnt == 4'd1)
          state_nxt = S_DONE;
      S_DONE:
        state_nxt = S_IDLE;
      default:
        state_nxt = S_IDLE;
    endcase
  end

  // counts down, preamble 8..1 with the sfd at 1, then fcs 4..1
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      cnt <= '0;
    else if (state == S_IDLE)
      cnt <= 4'(PREAMBLE_LEN + 1);
    else if (state == S_DATA)
      cnt <= 4'(FCS_LEN);
    else if (cnt != 4'd0)
      cnt <= cnt - 4'd1;
  end

  //////////////////////////////////////////////////
  // payload fetch
  //////////////////////////////////////////////////
  // byte 0 lands in data_dly on the first data cycle
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      data_req <= 1'b0;
    else
      data_req <= (state == S_PREAMBLE) && (cnt == 4'd3);
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      last_dly <= 1'b0;
    else
      last_dly <= frame_last;
  end

  always_ff @(posedge clk)
  begin
    data_dly <= frame_data;
  end

  // crc folds the payload while in data, reloads in idle
  assign crc.init = (state == S_IDLE);
  assign crc.en   = (state == S_DATA);
  assign crc.din  = data_dly;

  // inverted crc, lowest byte first
  always_comb
  begin
    case (cnt)
      4'd4:    fcs_byte = ~crc.result[7:0];
      4'd3:    fcs_byte = ~crc.result[15:8];
      4'd2:    fcs_byte = ~crc.result[23:16];
      default: fcs_byte = ~crc.result[31:24];
    endcase
  end

  //////////////////////////////////////////////////
  // output pipeline
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_en_pre    <= 1'b0;
      tx_en        <= 1'b0;
      send_end_pre <= 1'b0;
      send_end     <= 1'b0;
    end
    else
    begin
      tx_en_pre    <= (state == S_PREAMBLE) || (state == S_DATA) || (state == S_FCS);
      tx_en        <= tx_en_pre;
      send_end_pre <= (state == S_DONE);
      send_end     <= send_end_pre;  // one cycle after the last fcs byte
    end
  end

  always_ff @(posedge clk)
  begin
    case (state)
      S_PREAMBLE: tx_data_pre <= (cnt == 4'd1) ? SFD_BYTE : PREAMBLE_BYTE;
      S_DATA:     tx_data_pre <= data_dly;
      S_FCS:      tx_data_pre <= fcs_byte;
      default:    tx_data_pre <= 8'h00;
    endcase
    tx_data <= tx_data_pre;
  end

endmodule

// File: hdl/tx_frame_buffer.sv
// Wishbone classic slave for the transmit path
// single-frame byte memory with host write and readback
// length, control and status registers
// byte streamer toward the transmit controller

`timescale 1ns/1ps

module tx_frame_buffer
  import mac_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     cyc,
  input  logic     stb,
  input  logic     we,
  input  logic     data_req,
  input  logic     send_end,
  input  wb_adr_t  adr,
  input  wb_data_t wdata,
  output wb_data_t rdata,
  output logic     ack,
  output logic     tx_ready,
  output logic     frame_last,
  output byte_t    frame_data
);

  byte_t      mem [BUF_DEPTH];
  frame_len_t len_q;
  logic       busy;
  logic [7:0] sent_cnt;
  logic       streaming;
  buf_adr_t   rd_ptr;        // next byte after the current one
  buf_adr_t   rd_idx;
  buf_adr_t   last_idx;
  buf_adr_t   mem_idx;
  logic       stream_step;
  logic       wb_req;
  logic       is_reg;
  logic       start;

  //////////////////////////////////////////////////
  // bus decode
  //////////////////////////////////////////////////
  assign wb_req  = cyc && stb && !ack;  // not yet answered
  assign is_reg  = adr[11];
  assign mem_idx = adr[10:0];
  assign start   = wb_req && we && (adr == REG_CTRL) && wdata[0] && !busy &&
                   (len_q != '0) && (len_q <= MAX_FRAME_LEN);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      ack <= 1'b0;
    else
      ack <= wb_req;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      len_q <= '0;
    else if (wb_req && we && (adr == REG_LEN) && !busy)
      len_q <= wdata[10:0];  // held while a frame is out
  end

  // read data valid with ack
  always_ff @(posedge clk)
  begin
    if (wb_req && !we)
    begin
      if (!is_reg)
        rdata <= {24'h0, mem[mem_idx]};
      else
        case (adr)
          REG_CTRL:   rdata <= {31'h0, busy};
          REG_LEN:    rdata <= {21'h0, len_q};
          REG_STATUS: rdata <= {16'h0, sent_cnt, 7'h0, busy};
          default:    rdata <= '0;
        endcase
    end
  end

  //////////////////////////////////////////////////
  // frame handshake and status
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      tx_ready <= 1'b0;
      sent_cnt <= '0;
    end
    else
    begin
      if (start)
      begin
        busy     <= 1'b1;
        tx_ready <= 1'b1;
      end
      else if (data_req)
        tx_ready <= 1'b0;  // request taken
      if (send_end)
      begin
        busy     <= 1'b0;
        sent_cnt <= sent_cnt + 8'd1;
      end
    end
  end

  //////////////////////////////////////////////////
  // byte streamer
  //////////////////////////////////////////////////
  assign last_idx    = buf_adr_t'(len_q - 11'd1);
  assign rd_idx      = data_req ? '0 : rd_ptr;  // byte 0 right after the request
  assign stream_step = data_req || streaming;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      streaming  <= 1'b0;
      rd_ptr     <= '0;
      frame_last <= 1'b0;
    end
    else if (stream_step)
    begin
      streaming  <= (rd_idx != last_idx);
      rd_ptr     <= rd_idx + 11'd1;
      frame_last <= (rd_idx == last_idx);
    end
    else
      frame_last <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (wb_req && we && !is_reg)
      mem[mem_idx] <= wdata[7:0];
    if (stream_step)
      frame_data <= mem[rd_idx];
  end

endmodule

// File: hdl/mac_tx_top.sv
// top level of the transmit MAC
// Wishbone host port and byte-wide transmit output
// frame buffer, transmit controller and crc engine

`timescale 1ns/1ps

module mac_tx_top
  import mac_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     wb_cyc,
  input  logic     wb_stb,
  input  logic     wb_we,
  input  wb_adr_t  wb_adr,
  input  wb_data_t wb_wdata,
  output wb_data_t wb_rdata,
  output logic     wb_ack,
  output logic     tx_en,
  output byte_t    tx_data
);

  // buffer to controller stream
  logic  tx_ready;
  logic  data_req;
  logic  frame_last;
  logic  send_end;
  byte_t frame_data;

  crc_if crc_bus ();

  tx_frame_buffer u_buf (
    .clk        (clk),
    .rst_n      (rst_n),
    .cyc        (wb_cyc),
    .stb        (wb_stb),
    .we         (wb_we),
    .data_req   (data_req),
    .send_end   (send_end),
    .adr        (wb_adr),
    .wdata      (wb_wdata),
    .rdata      (wb_rdata),
    .ack        (wb_ack),
    .tx_ready   (tx_ready),
    .frame_last (frame_last),
    .frame_data (frame_data)
  );

  mac_tx u_tx (
    .clk        (clk),
    .rst_n      (rst_n),
    .tx_ready   (tx_ready),
    .frame_last (frame_last),
    .frame_data (frame_data),
    .data_req   (data_req),
    .send_end   (send_end),
    .tx_en      (tx_en),
    .tx_data    (tx_data),
    .crc        (crc_bus.ctrl)
  );

  crc32_d8 u_crc (
    .clk   (clk),
    .rst_n (rst_n),
    .crc   (crc_bus.engine)
  );

endmodule

// File: dv/tb_mac_tx_ref.svh
// reference model for the transmit MAC testbench
// bit-serial crc-32 over the payload, returned as the fcs
// expected tx byte stream, appended to the testbench queue exp_q

`ifndef TB_MAC_TX_REF_SVH
`define TB_MAC_TX_REF_SVH

// one bit per step, lsb of each byte first, result complemented
function automatic crc_t crc32_bitwise(input byte_t pl [MAX_FRAME_LEN], input int n);
  crc_t c;
  logic fb;
  c = 32'hffff_ffff;
  for (int i = 0; i < n; i++)
  begin
    for (int b = 0; b < 8; b++)
    begin
      fb = c[0] ^ pl[i][b];
      c  = c >> 1;
      if (fb)
        c = c ^ 32'hedb8_8320;  // 04c11db7 bit-reversed
    end
  end
  return ~c;
endfunction

//////////////////////////////////////////////////
// expected frame on the wire
//////////////////////////////////////////////////
function automatic void append_stream(input byte_t pl [MAX_FRAME_LEN], input int n);
  crc_t fcs;
  fcs = crc32_bitwise(pl, n);
  for (int i = 0; i < 7; i++)
    exp_q.push_back(8'h55);  // preamble
  exp_q.push_back(8'hd5);    // sfd
  for (int i = 0; i < n; i++)
    exp_q.push_back(pl[i]);
  // fcs goes out lowest byte first
  for (int k = 0; k < 4; k++)
    exp_q.push_back(fcs[8*k +: 8]);
endfunction

`endif

// File: dv/tb_mac_tx.sv
// testbench for the transmit MAC top level
// clock, reset and Wishbone host tasks
// tx_en monitor with byte capture and a compare process
// directed tests and a watchdog

`timescale 1ns/1ps

module tb_mac_tx
  import mac_pkg::*;
();

  localparam int CLK_NS = 100;
  // payload lengths in run order, zero where a test sends no frame
  localparam int TEST_LENS [9] = '{0, 64, 1, 1536, 16, 32, 0, 20, 48};

  logic     clk;
  logic     rst_n;
  logic     wb_cyc;
  logic     wb_stb;
  logic     wb_we;
  wb_adr_t  wb_adr;
  wb_data_t wb_wdata;
  wb_data_t wb_rdata;
  logic     wb_ack;
  logic     tx_en;
  byte_t    tx_data;

  int       seed = 32'h249a_5d3b;
  int       errors;
  int       sent_exp;         // frames the buffer should have counted
  int       frames_expected;
  int       frames_checked;
  int       bursts_done;
  int       run_len;
  byte_t    payload [MAX_FRAME_LEN];
  byte_t    cap_q [$];        // bytes seen while tx_en high
  byte_t    exp_q [$];
  int       burst_len_q [$];
  int       exp_len_q [$];
  string    name_q [$];
  wb_data_t rd;

  `include "tb_mac_tx_ref.svh"

  mac_tx_top UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_wdata (wb_wdata),
    .wb_rdata (wb_rdata),
    .wb_ack   (wb_ack),
    .tx_en    (tx_en),
    .tx_data  (tx_data)
  );

  always #(CLK_NS / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // host tasks, called 1 ns after a rising edge
  //////////////////////////////////////////////////
  task automatic wb_write(input wb_adr_t a, input wb_data_t d);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = a;
    wb_wdata = d;
    do
    begin
      @(posedge clk);
      #1;
    end
    while (wb_ack !== 1'b1);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_read(input wb_adr_t a, output wb_data_t d);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = a;
    do
    begin
      @(posedge clk);
      #1;
    end
    while (wb_ack !== 1'b1);
    d      = wb_rdata;  // valid with ack
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  // busy in bit 0, sent count in bits 15:8
  function automatic wb_data_t status_word(input logic busy, input int cnt);
    return {16'h0, cnt[7:0], 7'h0, busy};
  endfunction

  task automatic check_word(input string name, input wb_data_t exp, input wb_data_t act);
    if (act !== exp)
    begin
      $display("Fail %s: expected %08h, actual %08h", name, exp, act);
      errors++;
    end
  endtask

  task automatic fill_payload(input int n);
    int r;
    for (int i = 0; i < n; i++)
    begin
      r          = $random(seed);
      payload[i] = r[7:0];
    end
  endtask

  task automatic load_frame(input int n);
    for (int i = 0; i < n; i++)
      wb_write(wb_adr_t'(i), {24'h0, payload[i]});
    wb_write(REG_LEN, wb_data_t'(n));
  endtask

  task automatic expect_frame(input string name, input int n);
    append_stream(payload, n);
    exp_len_q.push_back(n + 12);  // preamble and sfd, payload, fcs
    name_q.push_back(name);
    frames_expected++;
  endtask

  task automatic wait_idle(output wb_data_t st);
    do
      wb_read(REG_STATUS, st);
    while (st[0]);
  endtask

  task automatic wait_tx_start();
    do
    begin
      @(posedge clk);
      #1;
    end
    while (tx_en !== 1'b1);
  endtask

  task automatic send_frame(input string name, input int n);
    wb_data_t st;
    fill_payload(n);
    load_frame(n);
    expect_frame(name, n);
    wb_write(REG_CTRL, 32'h1);
    sent_exp++;
    wait_idle(st);
    check_word({name, " status"}, status_word(1'b0, sent_exp), st);
  endtask

  //////////////////////////////////////////////////
  // tx monitor and compare
  //////////////////////////////////////////////////
  always @(negedge clk)
  begin
    if (tx_en === 1'b1)
    begin
      cap_q.push_back(tx_data);
      run_len++;
    end
    else if (run_len != 0)
    begin
      burst_len_q.push_back(run_len);  // tx_en fell, burst closed
      run_len = 0;
      bursts_done++;
    end
  end

  initial
  begin : compare
    int    got_len;
    int    exp_len;
    string name;
    byte_t got;
    byte_t want;
    forever
    begin
      wait (bursts_done > frames_checked);
      got_len = burst_len_q.pop_front();
      if (exp_len_q.size() == 0)
      begin
        $display("tx_en burst of %0d bytes without a started frame", got_len);
        errors++;
        for (int i = 0; i < got_len; i++)
          got = cap_q.pop_front();
      end
      else
      begin
        exp_len = exp_len_q.pop_front();
        name    = name_q.pop_front();
        if (got_len < exp_len)
        begin
          $display("%s: tx_en high for %0d cycles, %0d bytes missing", name, got_len,
                   exp_len - got_len);
          errors++;
        end
        else if (got_len > exp_len)
        begin
          $display("%s: tx_en high for %0d cycles, %0d extra bytes", name, got_len,
                   got_len - exp_len);
          errors++;
        end
        for (int i = 0; i < exp_len; i++)
        begin
          want = exp_q.pop_front();
          if (i < got_len)
          begin
            got = cap_q.pop_front();
            if (got !== want)
            begin
              $display("Fail %s byte %0d: expected %02h, actual %02h", name, i, want, got);
              errors++;
            end
          end
        end
        for (int i = exp_len; i < got_len; i++)
          got = cap_q.pop_front();
      end
      frames_checked++;
    end
  end

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////
  initial
  begin : tests
    clk      = 1'b0;
    rst_n    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_wdata = '0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // state after reset
    check_word("reset_tx_en", 32'h0, {31'h0, tx_en});
    wb_read(REG_STATUS, rd);
    check_word("reset_status", status_word(1'b0, 0), rd);

    send_frame("frame_64", 64);
    send_frame("frame_1", 1);
    send_frame("frame_1536", 1536);

    // register readback, busy while sending
    fill_payload(16);
    load_frame(16);
    wb_read(REG_LEN, rd);
    check_word("readback_len", 32'd16, rd);
    wb_read(wb_adr_t'(5), rd);
    check_word("readback_mem", {24'h0, payload[5]}, rd);
    expect_frame("readback_16", 16);
    wb_write(REG_CTRL, 32'h1);
    sent_exp++;
    wait_tx_start();
    wb_read(REG_STATUS, rd);
    check_word("status_busy", status_word(1'b1, sent_exp - 1), rd);
    wait_idle(rd);
    check_word("status_after", status_word(1'b0, sent_exp), rd);

    // starts that must be ignored
    fill_payload(32);
    load_frame(32);
    expect_frame("busy_start_32", 32);
    wb_write(REG_CTRL, 32'h1);
    sent_exp++;
    wait_tx_start();
    repeat (16) @(posedge clk);  // frame is into its payload here
    #1;
    wb_write(REG_CTRL, 32'h1);  // still busy
    wait_idle(rd);
    check_word("busy_start_count", status_word(1'b0, sent_exp), rd);
    wb_write(REG_LEN, 32'h0);
    wb_write(REG_CTRL, 32'h1);
    repeat (30) @(posedge clk);
    #1;
    wb_read(REG_STATUS, rd);
    check_word("zero_len_count", status_word(1'b0, sent_exp), rd);

    // back to back, crc reload between frames
    send_frame("b2b_a_20", 20);
    send_frame("b2b_b_48", 48);

    wait (frames_checked == frames_expected);
    repeat (20) @(posedge clk);
    if (bursts_done != frames_expected)
    begin
      $display("%0d tx_en bursts seen for %0d started frames", bursts_done, frames_expected);
      errors++;
    end
    $display("frames compared %0d, errors %0d", frames_checked, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  // budget per test covers loading, the frame and register traffic
  initial
  begin : watchdog
    longint cycles;
    cycles = 0;
    for (int i = 0; i < 9; i++)
      cycles += 3 * TEST_LENS[i] + 12 + 40;
    #(2 * cycles * CLK_NS);
    $display("watchdog expired after %0d cycles, run did not finish", 2 * cycles);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: tb.f
+incdir+dv
hdl/mac_pkg.sv
hdl/crc_if.sv
hdl/crc32_d8.sv
hdl/mac_tx.sv
hdl/tx_frame_buffer.sv
hdl/mac_tx_top.sv
dv/tb_mac_tx.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP      = tb_mac_tx
FILELIST = tb.f
OBJDIR   = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJDIR)
